// ==== build.f ====
hdl/divsqrt_cfg_pkg.sv
hdl/divsqrt_op_pkg.sv
hdl/divsqrt_core_if.sv
hdl/divsqrt_pipe_regs.sv
hdl/divsqrt_iter.sv
hdl/divsqrt_ctrl.sv
hdl/divsqrt_multi.sv
verif/divsqrt_multi_checker.sv
verif/tb_divsqrt_multi.sv

// ==== hdl/divsqrt_cfg_pkg.sv ====
// Divide/sqrt unit configuration: data width, register stage counts, iteration count
`default_nettype none

package divsqrt_cfg_pkg;

  // ----------------------------
  // Datapath
  // ----------------------------
  // Operand and result width
  localparam int unsigned DATA_W = 16;

  // ----------------------------
  // Register stages
  // ----------------------------
  // Stages ahead of the control FSM
  localparam int unsigned NUM_INP_REGS = 1;
  // Stages behind the hold register
  localparam int unsigned NUM_OUT_REGS = 1;

  // One result bit per cycle
  localparam int unsigned ITER_CYCLES = DATA_W;
  localparam int unsigned CNT_W       = 5;

endpackage : divsqrt_cfg_pkg

`default_nettype wire

// ==== hdl/divsqrt_core_if.sv ====
// Start/done link between the divide/sqrt control FSM and the iterative core
`timescale 1ns/1ps
`default_nettype none

interface divsqrt_core_if
  import divsqrt_cfg_pkg::*, divsqrt_op_pkg::*;
();

  // Issue side
  logic              start;      // single-cycle pulse, only while ready
  op_e               op;
  logic [DATA_W-1:0] operand_a;
  logic [DATA_W-1:0] operand_b;
  logic              kill;       // abort, core idle on the next cycle

  // Completion side
  logic              ready;      // core can take a start
  logic              done;       // ITER_CYCLES after start
  logic [DATA_W-1:0] result;     // valid in the done cycle only
  status_t           status;

  // Control FSM view
  modport ctrl (
    output start, op, operand_a, operand_b, kill,
    input  ready, done, result, status
  );

  // Arithmetic core view
  modport core (
    input  start, op, operand_a, operand_b, kill,
    output ready, done, result, status
  );

endinterface : divsqrt_core_if

`default_nettype wire

// ==== hdl/divsqrt_ctrl.sv ====
// Issue/hold FSM between input stage, iterative core and output stage
`timescale 1ns/1ps
`default_nettype none

module divsqrt_ctrl
  import divsqrt_op_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          flush_i,
  input  logic          in_valid_i,
  output logic          in_ready_o,
  input  in_word_t      in_word_i,
  divsqrt_core_if.ctrl  core,
  output logic          out_valid_o,
  input  logic          out_ready_i,
  output out_word_t     out_word_o,
  output logic          busy_o
);

  typedef enum logic [1:0] {IDLE, BUSY, HOLD} state_e;

  state_e    state_q, state_d;
  out_word_t unit_word;
  out_word_t held_q;

  // ----------------------------
  // Core issue
  // ----------------------------
  assign core.op        = in_word_i.op;
  assign core.operand_a = in_word_i.operand_a;
  assign core.operand_b = in_word_i.operand_b;
  // in_ready_o already low during flush
  assign core.start     = in_valid_i & in_ready_o;
  assign core.kill      = flush_i;

  // ----------------------------
  // FSM
  // ----------------------------
  always_comb begin : fsm_comb
    state_d     = state_q;
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    unique case (state_q)
      // Waiting for work
      IDLE: begin
        in_ready_o = core.ready;
        if (in_valid_i && core.ready) begin
          state_d = BUSY;
        end
      end
      // Core running, offer the result on done
      BUSY: begin
        busy_o = 1'b1;
        if (core.done) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Result leaves, next op may start in the same cycle
            state_d    = in_valid_i ? BUSY : IDLE;
            in_ready_o = core.ready;
          end else begin
            state_d = HOLD;
          end
        end
      end
      // Re-offer held copy until taken
      HOLD: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d    = in_valid_i ? BUSY : IDLE;
          in_ready_o = core.ready;
        end
      end
      default: state_d = IDLE;
    endcase
    // Flush drops everything
    if (flush_i) begin
      state_d     = IDLE;
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------
  // Hold register, output select
  // ----------------------------
  assign unit_word.result = core.result;
  assign unit_word.status = core.status;

  // Capture on done when downstream refuses
  always_ff @(posedge clk_i) begin
    if (core.done && !out_ready_i) begin
      held_q <= unit_word;
    end
  end

  assign out_word_o = (state_q == HOLD) ? held_q : unit_word;

endmodule : divsqrt_ctrl

`default_nettype wire

// ==== hdl/divsqrt_iter.sv ====
// Radix-2 restoring engine for unsigned divide and floor square root
`timescale 1ns/1ps
`default_nettype none

module divsqrt_iter
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic          clk_i,
  input  logic          arst_n_i,
  divsqrt_core_if.core  core
);

  // Control state
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             step_en;

  // Working registers
  op_e                 op_q, op_cur;
  logic [DATA_W-1:0]   dvs_q, dvs_cur;          // divisor
  logic [2*DATA_W-1:0] src_q, src_cur, src_nxt; // dividend or radicand bits still to bring down
  logic [DATA_W+1:0]   rem_q, rem_cur, rem_nxt; // partial remainder
  logic [DATA_W-1:0]   quo_q, quo_cur, quo_nxt; // quotient or root
  logic [DATA_W+3:0]   rem_sh, trial;
  logic [DATA_W+1:0]   diff;
  logic                take;

  // ----------------------------
  // Sequencing
  // ----------------------------
  // First step happens on the start edge, done after ITER_CYCLES-1 more
  assign core.done  = busy_q & (cnt_q == '0);
  // Ready again in the done cycle for back-to-back issue
  assign core.ready = ~busy_q | core.done;
  assign step_en    = busy_q & (cnt_q != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (core.kill) begin
      busy_q <= 1'b0;
    end else if (core.start) begin
      busy_q <= 1'b1;
      cnt_q  <= CNT_W'(ITER_CYCLES - 1);
    end else if (step_en) begin
      cnt_q <= cnt_q - 1'b1;
    end else begin
      busy_q <= 1'b0;
    end
  end

  // ----------------------------
  // Iteration step
  // ----------------------------
  always_comb begin
    // Start operands feed the first step directly
    if (core.start) begin
      op_cur  = core.op;
      dvs_cur = core.operand_b;
      rem_cur = '0;
      quo_cur = '0;
      // Divide takes one bit from the top, sqrt two bits of zero-extended a
      src_cur = (core.op == OP_DIV) ? {core.operand_a, {DATA_W{1'b0}}}
                                    : {{DATA_W{1'b0}}, core.operand_a};
    end else begin
      op_cur  = op_q;
      dvs_cur = dvs_q;
      rem_cur = rem_q;
      quo_cur = quo_q;
      src_cur = src_q;
    end
    if (op_cur == OP_DIV) begin
      rem_sh  = {1'b0, rem_cur, src_cur[2*DATA_W-1]};
      trial   = {4'b0000, dvs_cur};
      src_nxt = src_cur << 1;
    end else begin
      // Trial subtrahend is 4*root + 1
      rem_sh  = {rem_cur, src_cur[2*DATA_W-1 -: 2]};
      trial   = {2'b00, quo_cur, 2'b01};
      src_nxt = src_cur << 2;
    end
    take    = (rem_sh >= trial);
    diff    = rem_sh[DATA_W+1:0] - trial[DATA_W+1:0];
    // Restore by keeping the shifted remainder
    rem_nxt = take ? diff : rem_sh[DATA_W+1:0];
    quo_nxt = {quo_cur[DATA_W-2:0], take};
  end

  always_ff @(posedge clk_i) begin
    if (core.start) begin
      op_q  <= core.op;
      dvs_q <= core.operand_b;
    end
    if (core.start || step_en) begin
      src_q <= src_nxt;
      rem_q <= rem_nxt;
      quo_q <= quo_nxt;
    end
  end

  // Zero divisor gives all ones; its remainder does not count as inexact
  assign core.status.div_zero = (op_q == OP_DIV) && (dvs_q == '0);
  assign core.status.inexact  = (rem_q != '0) && !core.status.div_zero;
  assign core.result          = core.status.div_zero ? '1 : quo_q;

endmodule : divsqrt_iter

`default_nettype wire

// ==== hdl/divsqrt_multi.sv ====
// Multi-cycle unsigned divide/sqrt unit top: input stage, control, core, output stage
`timescale 1ns/1ps
`default_nettype none

module divsqrt_multi
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input  logic              clk_i,
  input  logic              arst_n_i,
  // Input handshake
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  op_e               op_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic              flush_i,
  // Output handshake
  output logic              out_valid_o,
  input  logic              out_ready_i,
  output logic [DATA_W-1:0] result_o,
  output status_t           status_o,
  // Anything in flight
  output logic              busy_o
);

  in_word_t  in_word, inp_word;
  out_word_t res_word, out_word;
  logic      inp_valid, inp_ready;
  logic      res_valid, res_ready;
  logic      inp_busy, ctrl_busy, out_busy;

  divsqrt_core_if core_if ();

  assign in_word.op        = op_i;
  assign in_word.operand_a = operand_a_i;
  assign in_word.operand_b = operand_b_i;

  // Input register stage
  divsqrt_pipe_regs #(.data_t(in_word_t), .NUM_STAGES(NUM_INP_REGS)) inp_regs_inst (
    .clk_i, .arst_n_i, .flush_i,
    .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (in_word),
    .valid_o (inp_valid),  .ready_i (inp_ready),  .data_o (inp_word),
    .busy_o  (inp_busy)
  );

  // Issue and hold control
  divsqrt_ctrl ctrl_inst (
    .clk_i, .arst_n_i, .flush_i,
    .in_valid_i  (inp_valid), .in_ready_o (inp_ready), .in_word_i (inp_word),
    .core        (core_if.ctrl),
    .out_valid_o (res_valid), .out_ready_i (res_ready), .out_word_o (res_word),
    .busy_o      (ctrl_busy)
  );

  // Arithmetic core
  divsqrt_iter iter_inst (.clk_i, .arst_n_i, .core (core_if.core));

  // Output register stage
  divsqrt_pipe_regs #(.data_t(out_word_t), .NUM_STAGES(NUM_OUT_REGS)) out_regs_inst (
    .clk_i, .arst_n_i, .flush_i,
    .valid_i (res_valid),   .ready_o (res_ready),   .data_i (res_word),
    .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (out_word),
    .busy_o  (out_busy)
  );

  assign result_o = out_word.result;
  assign status_o = out_word.status;
  assign busy_o   = inp_busy | ctrl_busy | out_busy;

endmodule : divsqrt_multi

`default_nettype wire

// ==== hdl/divsqrt_op_pkg.sv ====
// Divide/sqrt operation code, status flags and stage payload words
`default_nettype none

package divsqrt_op_pkg;
  import divsqrt_cfg_pkg::*;

  // Operation select
  typedef enum logic {OP_DIV, OP_SQRT} op_e;

  // Result flags
  typedef struct packed {
    logic div_zero;  // divisor was zero, quotient forced to all ones
    logic inexact;   // nonzero final remainder
  } status_t;

  // Input stage payload
  typedef struct packed {
    op_e               op;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
  } in_word_t;

  // Output stage payload
  typedef struct packed {
    logic [DATA_W-1:0] result;
    status_t           status;
  } out_word_t;

endpackage : divsqrt_op_pkg

`default_nettype wire

// ==== hdl/divsqrt_pipe_regs.sv ====
// Valid/ready register chain with synchronous flush, any payload type
`timescale 1ns/1ps
`default_nettype none

module divsqrt_pipe_regs #(
  parameter type         data_t     = logic,
  parameter int unsigned NUM_STAGES = 1
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  flush_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o,
  output logic  busy_o
);

  // Index i is the view after i stages, index 0 is the chain input
  logic  valid_q [0:NUM_STAGES];
  logic  ready   [0:NUM_STAGES];
  data_t data_q  [0:NUM_STAGES];

  assign valid_q[0] = valid_i;
  assign data_q[0]  = data_i;
  assign ready_o    = ready[0];

  for (genvar i = 0; i < NUM_STAGES; i++) begin : gen_stage
    logic load;
    // Advance when next stage takes its item or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Payload moves only with a real item
    assign load = ready[i] & valid_q[i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Downstream ready enters at the far end
  assign ready[NUM_STAGES] = ready_i;
  assign valid_o           = valid_q[NUM_STAGES];
  assign data_o            = data_q[NUM_STAGES];

  // Any stage holding an item, zero stages never busy
  always_comb begin
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NUM_STAGES; i++) begin
      busy_o = busy_o | valid_q[i];
    end
  end

endmodule : divsqrt_pipe_regs

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the divide/sqrt testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_divsqrt_multi \
  -f build.f -o sim_tb || exit 1
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// ==== verif/divsqrt_multi_checker.sv ====
// Concurrent assertions on the divide/sqrt unit output handshake and busy flag
`timescale 1ns/1ps
`default_nettype none

module divsqrt_multi_checker
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
(
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              flush_i,
  input logic              out_valid_o,
  input logic              out_ready_i,
  input logic [DATA_W-1:0] result_o,
  input status_t           status_o,
  input logic              busy_o
);

  // Failure count the testbench reads at the end
  int unsigned fail_cnt = 0;

  // Nothing offered while reset holds
  reset_quiet_a: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_o && !busy_o)
    else begin
      $error("out_valid_o or busy_o high during reset");
      fail_cnt++;
    end

  // ----------------------------
  // Output stall
  // ----------------------------
  // Offered result holds until taken unless flushed
  out_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o && !out_ready_i && !flush_i
      |=> out_valid_o && $stable(result_o) && $stable(status_o))
    else begin
      $error("output dropped or changed while stalled");
      fail_cnt++;
    end

  // Result at the output was in flight the cycle before, so busy then and now
  busy_out_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      out_valid_o |-> busy_o && $past(busy_o))
    else begin
      $error("busy_o low while a result was pending");
      fail_cnt++;
    end

endmodule : divsqrt_multi_checker

bind divsqrt_multi divsqrt_multi_checker checker_inst (
  .clk_i, .arst_n_i, .flush_i, .out_valid_o, .out_ready_i, .result_o, .status_o, .busy_o
);

`default_nettype wire

// ==== verif/tb_divsqrt_multi.sv ====
// Testbench driving random divide/sqrt traffic against a reference model with timeout
`timescale 1ns/1ps
`default_nettype none

module tb_divsqrt_multi
  import divsqrt_cfg_pkg::*;
  import divsqrt_op_pkg::*;
();

  // ----------------------------
  // Run length
  // ----------------------------
  localparam int unsigned NUM_OPS    = 300;
  localparam int unsigned FLUSH_AT   = 250;
  localparam int unsigned MAX_CYCLES = NUM_OPS * 20 + 200;

  logic              clk_i = 1'b0;
  logic              arst_n_i;
  logic              in_valid_i;
  logic              in_ready_o;
  op_e               op_i;
  logic [DATA_W-1:0] operand_a_i;
  logic [DATA_W-1:0] operand_b_i;
  logic              flush_i;
  logic              out_valid_o;
  logic              out_ready_i;
  logic [DATA_W-1:0] result_o;
  status_t           status_o;
  logic              busy_o;

  integer      seed;
  out_word_t   exp_q [$];   // expected results in issue order
  logic        in_fire;     // input transfer on the coming edge
  int unsigned issued, received, cycle_cnt;
  int unsigned res_errs, stat_errs, flag_errs, proto_errs, assert_errs;

  divsqrt_multi divsqrt_multi_inst (
    .clk_i (clk_i), .arst_n_i (arst_n_i),
    .in_valid_i (in_valid_i), .in_ready_o (in_ready_o), .op_i (op_i),
    .operand_a_i (operand_a_i), .operand_b_i (operand_b_i), .flush_i (flush_i),
    .out_valid_o (out_valid_o), .out_ready_i (out_ready_i),
    .result_o (result_o), .status_o (status_o), .busy_o (busy_o)
  );

  // 20 ns period
  always #10 clk_i = ~clk_i;

  // ----------------------------
  // Reference model
  // ----------------------------
  function automatic out_word_t model_op(input op_e op, input logic [DATA_W-1:0] a,
                                         input logic [DATA_W-1:0] b);
    out_word_t   w;
    int unsigned av;
    int unsigned root;
    w  = '0;
    av = 32'(a);
    if (op == OP_SQRT) begin
      // Largest root whose square still fits
      root = 0;
      while ((root + 1) * (root + 1) <= av) begin
        root++;
      end
      w.result         = DATA_W'(root);
      w.status.inexact = (root * root != av);
    end else if (b == '0) begin
      // Zero divisor saturates and ignores the remainder
      w.result          = '1;
      w.status.div_zero = 1'b1;
    end else begin
      w.result         = a / b;
      w.status.inexact = ((a % b) != '0);
    end
    return w;
  endfunction

  // ----------------------------
  // Compare tasks
  // ----------------------------
  task automatic check_result(input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t result_o expected %h got %h", $time, exp, act);
      res_errs++;
    end
  endtask

  task automatic check_status(input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t status_o expected %b got %b", $time, exp, act);
      stat_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %b got %b", $time, name, exp, act);
      flag_errs++;
    end
  endtask

  // ----------------------------
  // Stimulus and scoreboard
  // ----------------------------
  // Mix of sqrt, perfect squares, wide and narrow divisors, zero divisors
  task automatic pick_op();
    int unsigned sel;
    int unsigned r;
    sel         = $unsigned($random(seed)) % 8;
    r           = $unsigned($random(seed)) % 256;
    op_i        = (sel < 3) ? OP_SQRT : OP_DIV;
    operand_a_i = (sel == 2) ? DATA_W'(r * r) : DATA_W'($random(seed));
    operand_b_i = DATA_W'($random(seed));
    if (sel == 6) begin
      operand_b_i = operand_b_i & DATA_W'(8'hff);
    end
    if (sel == 7) begin
      operand_b_i = '0;
    end
  endtask

  task automatic take_output();
    out_word_t exp;
    if (exp_q.size() == 0) begin
      $display("ERROR t=%0t: result offered with no operation outstanding", $time);
      proto_errs++;
    end else begin
      exp = exp_q.pop_front();
      check_result(exp.result, result_o);
      check_status(exp.status, status_o);
      received++;
    end
  endtask

  // One clock of driving on the falling edge and judging the coming rising edge
  task automatic step_cycle();
    @(negedge clk_i);
    // Keep an offered op until it is taken
    if (!in_valid_i || in_fire) begin
      in_valid_i = (issued < NUM_OPS) && (($random(seed) & 3) != 0);
      if (in_valid_i) begin
        pick_op();
      end
    end
    out_ready_i = ($unsigned($random(seed)) % 10) < 7;
    #1;
    in_fire = in_valid_i && in_ready_o;
    if (in_fire) begin
      exp_q.push_back(model_op(op_i, operand_a_i, operand_b_i));
      issued++;
    end
    if (out_valid_o && out_ready_i) begin
      take_output();
    end
  endtask

  // Cancel everything in flight with downstream quiet during the flush edge
  task automatic flush_cycle();
    @(negedge clk_i);
    flush_i     = 1'b1;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    in_fire     = 1'b0;
    @(negedge clk_i);
    flush_i = 1'b0;
    exp_q.delete();
    #1;
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("out_valid_o", 1'b0, out_valid_o);
  endtask

  // ----------------------------
  // Timeout
  // ----------------------------
  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("ERROR t=%0t: run did not finish within %0d cycles", $time, MAX_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  // ----------------------------
  // Test sequence
  // ----------------------------
  initial begin : main
    seed        = 32'h4d0bd7f2;
    arst_n_i    = 1'b1;
    in_valid_i  = 1'b0;
    op_i        = OP_DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    flush_i     = 1'b0;
    out_ready_i = 1'b0;
    in_fire     = 1'b0;
    issued      = 0;
    received    = 0;
    res_errs    = 0;
    stat_errs   = 0;
    flag_errs   = 0;
    proto_errs  = 0;
    // Clean falling edge on the reset input
    #2 arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    #1;
    // Idle state straight after reset
    check_flag("out_valid_o", 1'b0, out_valid_o);
    check_flag("busy_o", 1'b0, busy_o);
    check_flag("in_ready_o", 1'b1, in_ready_o);

    // Random traffic under back-pressure
    while (issued < FLUSH_AT) begin
      step_cycle();
    end
    // Flush with at least two ops in flight
    while (exp_q.size() < 2) begin
      step_cycle();
    end
    flush_cycle();
    // Remaining ops and the final drain
    while (issued < NUM_OPS || exp_q.size() != 0) begin
      step_cycle();
    end
    step_cycle();
    check_flag("busy_o", 1'b0, busy_o);

    assert_errs = divsqrt_multi_inst.checker_inst.fail_cnt;
    $display("Checked %0d results, errors: res %0d stat %0d flag %0d proto %0d assert %0d",
             received, res_errs, stat_errs, flag_errs, proto_errs, assert_errs);
    if (res_errs + stat_errs + flag_errs + proto_errs + assert_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : tb_divsqrt_multi

`default_nettype wire
